// File: common/spi_pkg.sv
////////////////////////////////////////////////////////////
// spi frame definitions
// one frame is an address byte followed by a value byte
////////////////////////////////////////////////////////////

`default_nettype none

package spi_pkg;

  // only legal frame length, in sclk cycles
  localparam int FRAME_BITS = 16;

  // msb first on the wire, so addr is shifted in before val
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] val;
  } spi_frame_t;

endpackage

`default_nettype wire

// File: common/regmap_pkg.sv
////////////////////////////////////////////////////////////
// control register map
// addresses, set/clear value layout and register payloads
////////////////////////////////////////////////////////////

`default_nettype none

package regmap_pkg;

  // register addresses, the gaps are unused
  typedef enum logic [7:0] {
    POWERUP_CLR = 8'd6,
    LED         = 8'd7,
    MUX         = 8'd8,
    DAC         = 8'd9,
    SOFT_RST    = 8'd11,
    ADC         = 8'd14
  } reg_addr_e;

  // value byte of a set/clear/toggle write
  // both bits of a pair set means toggle
  typedef struct packed {
    logic [3:0] clr;
    logic [3:0] set;
  } sct_val_t;

  // board led enables
  typedef struct packed {
    logic [3:0] en;
  } led_ctl_t;

  // dac control lines
  typedef struct packed {
    logic rst;
    logic uni_bip_b;
    logic uni_bip_a;
    logic ldac;
  } dac_ctl_t;

  // adc reset and mode pins
  typedef struct packed {
    logic rst;
    logic m2;
    logic m1;
    logic m0;
  } adc_ctl_t;

  // dac comes up held in reset with ldac high
  localparam dac_ctl_t DAC_RST_VAL = '{rst: 1'b1, uni_bip_b: 1'b1, uni_bip_a: 1'b1, ldac: 1'b1};

endpackage

`default_nettype wire

// File: spi_slave/spi_frame_rx.sv
////////////////////////////////////////////////////////////
// spi mode 0 slave, oversampled in the clk domain
// shifts in 16 bit frames, strobes the address byte
// and shifts register read data back out on sdo
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module spi_frame_rx (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  output logic                  sdo,
  output logic                  rd_strobe,
  output regmap_pkg::reg_addr_e rd_addr,
  input  logic [7:0]            rd_data,
  output logic                  frame_done,
  output spi_pkg::spi_frame_t   frame
);

  import spi_pkg::*;
  import regmap_pkg::*;

  localparam int ADDR_BITS = $bits(reg_addr_e);
  // room to count past a full frame
  localparam int CNT_BITS  = $clog2(FRAME_BITS + 2);

  // [0] is the first sync flop, [2] only feeds edge detect
  logic [2:0]            sclk_sh;
  logic [2:0]            cs_sh;
  logic [1:0]            mosi_sh;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_rise;
  logic                  cs_fall;
  logic                  cs_active;
  logic                  addr_bit;
  logic [CNT_BITS-1:0]   bit_cnt;
  logic [FRAME_BITS-1:0] rx_sh;
  logic [7:0]            tx_sh;
  logic                  rd_pend;

  ////////////////////////////////////////////////////////////
  // pin synchronizers

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // idle bus, chip select released
      sclk_sh <= '0;
      cs_sh   <= '1;
      mosi_sh <= '0;
    end
    else
    begin
      sclk_sh <= {sclk_sh[1:0], sclk};
      cs_sh   <= {cs_sh[1:0], cs_n};
      mosi_sh <= {mosi_sh[0], mosi};
    end
  end

  assign sclk_rise = sclk_sh[1] & ~sclk_sh[2];
  assign sclk_fall = ~sclk_sh[1] & sclk_sh[2];
  assign cs_rise   = cs_sh[1] & ~cs_sh[2];
  assign cs_fall   = ~cs_sh[1] & cs_sh[2];
  assign cs_active = ~cs_sh[1];

  // last bit of the address byte arriving now
  assign addr_bit  = cs_active && sclk_rise && (bit_cnt == CNT_BITS'(ADDR_BITS - 1));

  ////////////////////////////////////////////////////////////
  // bit count, strobes and reply shifter

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt    <= '0;
      rd_strobe  <= 1'b0;
      rd_pend    <= 1'b0;
      frame_done <= 1'b0;
      tx_sh      <= '0;
      sdo        <= 1'b0;
    end
    else
    begin
      rd_strobe  <= addr_bit;
      // bank answers one clk after the strobe
      rd_pend    <= rd_strobe;
      // only an exact 16 bit frame is handed on
      frame_done <= cs_rise && (bit_cnt == CNT_BITS'(FRAME_BITS));

      // saturates at 17, anything past 16 is a bad frame
      if (cs_fall)
        bit_cnt <= '0;
      else if (cs_active && sclk_rise && (bit_cnt <= CNT_BITS'(FRAME_BITS)))
        bit_cnt <= bit_cnt + 1'b1;

      // reply upper byte is zeros, shifted out before the load
      if (cs_fall || cs_rise)
      begin
        tx_sh <= '0;
        sdo   <= 1'b0;
      end
      else if (rd_pend)
        tx_sh <= rd_data;
      else if (cs_active && sclk_fall)
        {sdo, tx_sh} <= {tx_sh, 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////
  // receive data path

  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_rise)
      rx_sh <= {rx_sh[FRAME_BITS-2:0], mosi_sh[1]};
    // address is complete including the bit sampled now
    if (addr_bit)
      rd_addr <= reg_addr_e'({rx_sh[ADDR_BITS-2:0], mosi_sh[1]});
    if (cs_rise)
      frame <= spi_frame_t'(rx_sh);
  end

endmodule

`default_nettype wire

// File: reg_bank/sct_reg.sv
////////////////////////////////////////////////////////////
// set/clear/toggle control register
// per bit: set -> 1, clr -> 0, both -> invert
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sct_reg #(
  parameter type      payload_t = regmap_pkg::led_ctl_t,
  parameter payload_t RST_VAL   = '0
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wr,
  input  regmap_pkg::sct_val_t val,
  input  logic                 clr_all,
  output payload_t             q
);

  localparam int W = $bits(payload_t);

  logic [W-1:0] cur;
  logic [W-1:0] both;
  logic [W-1:0] nxt;

  assign cur  = q;
  assign both = val.set & val.clr;
  // set and clr first, then flip the bits given both
  assign nxt  = ((cur | val.set) & ~val.clr) | (both & ~cur);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      q <= RST_VAL;
    else if (clr_all)
      q <= payload_t'('0);
    else if (wr)
      q <= payload_t'(nxt);
  end

endmodule

`default_nettype wire

// File: reg_bank/reg_bank.sv
////////////////////////////////////////////////////////////
// control register bank
// turns finished spi frames into register writes and
// clears, and returns the addressed register on reads
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module reg_bank #(
  parameter int N_PERIPH = 8
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  frame_done,
  input  spi_pkg::spi_frame_t   frame,
  input  logic                  rd_strobe,
  input  regmap_pkg::reg_addr_e rd_addr,
  output logic [7:0]            rd_data,
  output regmap_pkg::led_ctl_t  led,
  output regmap_pkg::dac_ctl_t  dac_ctl,
  output regmap_pkg::adc_ctl_t  adc_ctl,
  output logic [N_PERIPH-1:0]   mux_sel
);

  import regmap_pkg::*;

  logic                wr_led;
  logic                wr_dac;
  logic                wr_adc;
  logic                wr_mux;
  logic                soft_rst;
  logic                pwr_clr;
  sct_val_t            wr_val;
  logic [N_PERIPH-1:0] mux_next;

  ////////////////////////////////////////////////////////////
  // address decode

  assign wr_val   = sct_val_t'(frame.val);
  assign wr_led   = frame_done && (frame.addr == LED);
  assign wr_dac   = frame_done && (frame.addr == DAC);
  assign wr_adc   = frame_done && (frame.addr == ADC);
  assign wr_mux   = frame_done && (frame.addr == MUX);
  assign soft_rst = frame_done && (frame.addr == SOFT_RST);
  // rails check passed, dac config already done
  assign pwr_clr  = frame_done && (frame.addr == POWERUP_CLR);

  sct_reg #(
    .payload_t (led_ctl_t),
    .RST_VAL   ('0)
  ) led_reg_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr      (wr_led),
    .val     (wr_val),
    .clr_all (soft_rst | pwr_clr),
    .q       (led)
  );

  // dac keeps its setup across a powerup clear
  sct_reg #(
    .payload_t (dac_ctl_t),
    .RST_VAL   (DAC_RST_VAL)
  ) dac_reg_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr      (wr_dac),
    .val     (wr_val),
    .clr_all (soft_rst),
    .q       (dac_ctl)
  );

  sct_reg #(
    .payload_t (adc_ctl_t),
    .RST_VAL   ('0)
  ) adc_reg_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr      (wr_adc),
    .val     (wr_val),
    .clr_all (soft_rst | pwr_clr),
    .q       (adc_ctl)
  );

  ////////////////////////////////////////////////////////////
  // peripheral mux, value n selects bit n-1

  always_comb
  begin
    // 0 and anything above N_PERIPH match no bit
    for (int i = 0; i < N_PERIPH; i++)
      mux_next[i] = (frame.val == 8'(i + 1));
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      mux_sel <= '0;
    else if (soft_rst)
      mux_sel <= '0;
    else if (wr_mux)
      mux_sel <= mux_next;
  end

  // readback, latched on the address strobe
  always_ff @(posedge clk)
  begin
    if (rd_strobe)
    begin
      case (rd_addr)
        LED:     rd_data <= {4'b0000, led};
        MUX:     rd_data <= 8'(mux_sel);
        DAC:     rd_data <= {4'b0000, dac_ctl};
        ADC:     rd_data <= {4'b0000, adc_ctl};
        default: rd_data <= 8'h00;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/spi_route.sv
////////////////////////////////////////////////////////////
// second chip select router
// fans cs2_n out by the mux register, returns miso
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module spi_route #(
  parameter int N_PERIPH = 8
) (
  input  logic                cs2_n,
  input  logic [N_PERIPH-1:0] mux_sel,
  input  logic                sdo,
  input  logic [N_PERIPH-1:0] periph_miso,
  output logic [N_PERIPH-1:0] periph_cs_n,
  output logic                miso
);

  // purely combinational, follows cs2_n with no delay
  always_comb
  begin
    if (cs2_n)
    begin
      // nothing selected, bank slave owns miso
      periph_cs_n = '1;
      miso        = sdo;
    end
    else
    begin
      periph_cs_n = ~mux_sel;
      // unselected lines masked off
      miso        = |(mux_sel & periph_miso);
    end
  end

endmodule

`default_nettype wire

// File: verilog/gray_blinker.sv
////////////////////////////////////////////////////////////
// heartbeat blinker, free running 4 bit gray count
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module gray_blinker #(
  parameter int LOG2_DELAY = 20
) (
  input  logic       clk,
  input  logic       arst_n,
  output logic [3:0] heartbeat
);

  logic [LOG2_DELAY+3:0] counter;
  logic [3:0]            step_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      counter <= '0;
      step_q  <= '0;
    end
    else
    begin
      counter <= counter + 1'b1;
      // top nibble steps every 2**LOG2_DELAY clk
      step_q  <= counter[LOG2_DELAY+3:LOG2_DELAY];
    end
  end

  // binary to gray
  assign heartbeat = step_q ^ (step_q >> 1);

endmodule

`default_nettype wire

// File: verilog/board_ctrl_top.sv
////////////////////////////////////////////////////////////
// board controller top
// spi slave, register bank, cs router and heartbeat
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module board_ctrl_top #(
  parameter int N_PERIPH   = 8,
  parameter int LOG2_DELAY = 20
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // mcu side
  input  logic                 sclk,
  input  logic                 cs_n,
  input  logic                 mosi,
  input  logic                 cs2_n,
  output logic                 miso,
  // routed peripherals
  input  logic [N_PERIPH-1:0]  periph_miso,
  output logic [N_PERIPH-1:0]  periph_cs_n,
  output logic                 periph_sclk,
  output logic                 periph_mosi,
  // board control lines
  output regmap_pkg::led_ctl_t led,
  output logic [3:0]           heartbeat,
  output regmap_pkg::dac_ctl_t dac_ctl,
  output regmap_pkg::adc_ctl_t adc_ctl,
  input  logic                 adc_drdy_n,
  output logic                 irq_n
);

  import spi_pkg::*;
  import regmap_pkg::*;

  logic                sdo;
  logic                rd_strobe;
  reg_addr_e           rd_addr;
  logic [7:0]          rd_data;
  logic                frame_done;
  spi_frame_t          frame;
  logic [N_PERIPH-1:0] mux_sel;

  ////////////////////////////////////////////////////////////
  // pass through

  // sclk and mosi reach every peripheral, only cs is routed
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;
  // adc data ready is the only interrupt source
  assign irq_n       = adc_drdy_n;

  ////////////////////////////////////////////////////////////
  // blocks

  spi_frame_rx spi_frame_rx_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .sdo        (sdo),
    .rd_strobe  (rd_strobe),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_done (frame_done),
    .frame      (frame)
  );

  reg_bank #(
    .N_PERIPH (N_PERIPH)
  ) reg_bank_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .frame_done (frame_done),
    .frame      (frame),
    .rd_strobe  (rd_strobe),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .led        (led),
    .dac_ctl    (dac_ctl),
    .adc_ctl    (adc_ctl),
    .mux_sel    (mux_sel)
  );

  spi_route #(
    .N_PERIPH (N_PERIPH)
  ) spi_route_i (
    .cs2_n       (cs2_n),
    .mux_sel     (mux_sel),
    .sdo         (sdo),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  gray_blinker #(
    .LOG2_DELAY (LOG2_DELAY)
  ) gray_blinker_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .heartbeat (heartbeat)
  );

endmodule

`default_nettype wire

// File: dv/board_ctrl_props.sv
////////////////////////////////////////////////////////////
// board controller assertions
// frame strobe timing and chip select routing
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module board_ctrl_props #(
  parameter int N_PERIPH = 8
) (
  input logic                clk,
  input logic                arst_n,
  input logic                frame_done,
  input logic                cs_sync_n,
  input logic                cs2_n,
  input logic [N_PERIPH-1:0] periph_cs_n
);

  // count of failed assertions
  int fail_cnt = 0;

  // strobe follows the synchronized rising edge of cs_n
  a_done_cs_high: assert property (
    @(posedge clk) disable iff (!arst_n) frame_done |-> cs_sync_n
  )
  else
  begin
    $error("frame_done pulsed while synchronized cs_n was low");
    fail_cnt++;
  end

  // mux register is one-hot or empty
  a_cs_onehot: assert property (
    @(posedge clk) disable iff (!arst_n) $onehot0(~periph_cs_n)
  )
  else
  begin
    $error("more than one periph_cs_n low");
    fail_cnt++;
  end

  a_cs_idle: assert property (
    @(posedge clk) disable iff (!arst_n) cs2_n |-> (&periph_cs_n)
  )
  else
  begin
    $error("periph_cs_n low while cs2_n high");
    fail_cnt++;
  end

endmodule

bind board_ctrl_top board_ctrl_props #(
  .N_PERIPH (N_PERIPH)
) props_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .frame_done  (frame_done),
  .cs_sync_n   (spi_frame_rx_i.cs_sh[1]),
  .cs2_n       (cs2_n),
  .periph_cs_n (periph_cs_n)
);

`default_nettype wire

// File: dv/board_ctrl_tb.sv
////////////////////////////////////////////////////////////
// board controller testbench
// directed spi frames against a register model, chip
// select routing, short frames and heartbeat sequence
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module board_ctrl_tb;

  import spi_pkg::*;
  import regmap_pkg::*;

  localparam int N_PERIPH = 8;

  logic                clk;
  logic                arst_n;
  logic                sclk;
  logic                cs_n;
  logic                mosi;
  logic                cs2_n;
  logic                miso;
  logic [N_PERIPH-1:0] periph_miso;
  logic [N_PERIPH-1:0] periph_cs_n;
  logic                periph_sclk;
  logic                periph_mosi;
  led_ctl_t            led;
  logic [3:0]          heartbeat;
  dac_ctl_t            dac_ctl;
  adc_ctl_t            adc_ctl;
  logic                adc_drdy_n;
  logic                irq_n;

  int                  errors;
  int                  tests_run;
  int                  tests_failed;
  // expected register contents
  logic [3:0]          m_led;
  logic [3:0]          m_dac;
  logic [3:0]          m_adc;

  board_ctrl_top #(
    .N_PERIPH   (N_PERIPH),
    .LOG2_DELAY (2)
  ) dut_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .miso        (miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .led         (led),
    .heartbeat   (heartbeat),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl),
    .adc_drdy_n  (adc_drdy_n),
    .irq_n       (irq_n)
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers

  // inputs move 2 ns after the rising edge
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // per bit: set alone -> 1, clr alone -> 0, both -> flip
  function automatic logic [3:0] sct_model(input logic [3:0] cur, input sct_val_t v);
    logic [3:0] res;
    res = cur;
    for (int i = 0; i < 4; i++)
    begin
      case ({v.set[i], v.clr[i]})
        2'b10:   res[i] = 1'b1;
        2'b01:   res[i] = 1'b0;
        2'b11:   res[i] = ~cur[i];
        default: res[i] = cur[i];
      endcase
    end
    return res;
  endfunction

  // kind 0 set only, 1 clr only, 2 overlapping set and clr
  function automatic sct_val_t rand_sct(input int kind);
    sct_val_t v;
    v.set = 4'($urandom);
    v.clr = 4'($urandom);
    case (kind)
      0:       v.clr = 4'h0;
      1:       v.set = 4'h0;
      default: v.clr = v.clr | v.set;
    endcase
    return v;
  endfunction

  function automatic spi_frame_t make_frame(input reg_addr_e a, input logic [7:0] v);
    spi_frame_t f;
    f.addr = a;
    f.val  = v;
    return f;
  endfunction

  function automatic logic [3:0] gray_to_bin(input logic [3:0] g);
    logic [3:0] b;
    b[3] = g[3];
    for (int i = 2; i >= 0; i--)
      b[i] = b[i+1] ^ g[i];
    return b;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_led(input led_ctl_t exp, input string what);
    if (led !== exp)
    begin
      $display("MISMATCH led (%s): expected %h, got %h", what, exp, led);
      errors++;
    end
  endtask

  task automatic check_dac(input dac_ctl_t exp, input string what);
    if (dac_ctl !== exp)
    begin
      $display("MISMATCH dac_ctl (%s): expected %h, got %h", what, exp, dac_ctl);
      errors++;
    end
  endtask

  task automatic check_adc(input adc_ctl_t exp, input string what);
    if (adc_ctl !== exp)
    begin
      $display("MISMATCH adc_ctl (%s): expected %h, got %h", what, exp, adc_ctl);
      errors++;
    end
  endtask

  task automatic check_cs(input logic [N_PERIPH-1:0] exp, input string what);
    if (periph_cs_n !== exp)
    begin
      $display("MISMATCH periph_cs_n (%s): expected %h, got %h", what, exp, periph_cs_n);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp)
    begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp)
    begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    tests_run++;
    if (errors == start)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // spi master, mode 0, sclk at clk/8

  task automatic spi_xfer(input spi_frame_t data, input int nbits, output logic [15:0] rx);
    int   cnt;
    logic seen;
    rx   = '0;
    seen = 1'b0;
    cnt  = 0;
    cs_n = 1'b0;
    tick(4);
    for (int i = 0; i < nbits; i++)
    begin
      sclk = 1'b0;
      // frame aligned to the last bit, leading extras zero
      mosi = (nbits - 1 - i < FRAME_BITS) ? data[nbits-1-i] : 1'b0;
      tick(4);
      // reply bit sampled just before the rising edge
      if (i < FRAME_BITS)
        rx[FRAME_BITS-1-i] = miso;
      sclk = 1'b1;
      tick(4);
    end
    sclk = 1'b0;
    tick(4);
    cs_n = 1'b1;
    // look for the frame strobe
    while (!seen && cnt < 12)
    begin
      tick(1);
      seen = dut_i.frame_done;
      cnt++;
    end
    if (nbits == FRAME_BITS && !seen)
    begin
      $display("timeout waiting for frame_done after a full frame");
      errors++;
    end
    else if (nbits != FRAME_BITS && seen)
    begin
      $display("frame_done pulsed after a %0d bit frame", nbits);
      errors++;
    end
    // register update lands the clk after the strobe
    tick(2);
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic test_led_sct();
    sct_val_t    v;
    logic [15:0] rx;
    for (int i = 0; i < 12; i++)
    begin
      v = rand_sct(i % 3);
      spi_xfer(make_frame(LED, v), FRAME_BITS, rx);
      m_led = sct_model(m_led, v);
      check_led(m_led, "sct write");
    end
    // zero value byte changes nothing, so it reads
    spi_xfer(make_frame(LED, 8'h00), FRAME_BITS, rx);
    check_byte("led readback", {4'h0, m_led}, rx[7:0]);
    check_byte("reply upper byte", 8'h00, rx[15:8]);
  endtask

  task automatic test_dac_adc();
    sct_val_t    v;
    logic [15:0] rx;
    spi_xfer(make_frame(DAC, 8'h00), FRAME_BITS, rx);
    check_byte("dac reset readback", 8'h0f, rx[7:0]);
    check_dac(dac_ctl_t'(4'hf), "after reset");
    for (int i = 0; i < 8; i++)
    begin
      v = rand_sct(i % 3);
      spi_xfer(make_frame(DAC, v), FRAME_BITS, rx);
      m_dac = sct_model(m_dac, v);
      check_dac(m_dac, "sct write");
    end
    for (int i = 0; i < 8; i++)
    begin
      v = rand_sct(i % 3);
      spi_xfer(make_frame(ADC, v), FRAME_BITS, rx);
      m_adc = sct_model(m_adc, v);
      check_adc(m_adc, "sct write");
    end
  endtask

  task automatic test_mux_route();
    logic [N_PERIPH-1:0] sel;
    logic [15:0]         rx;
    // 0 and N_PERIPH+1 select nothing
    for (int n = 0; n <= N_PERIPH + 1; n++)
    begin
      spi_xfer(make_frame(MUX, 8'(n)), FRAME_BITS, rx);
      sel = '0;
      if (n >= 1 && n <= N_PERIPH)
        sel[n-1] = 1'b1;
      cs2_n       = 1'b0;
      periph_miso = sel;
      tick(1);
      check_cs(~sel, "cs2_n low");
      check_bit("miso from selected", |sel, miso);
      // other lines high, selected line low
      periph_miso = ~sel;
      tick(1);
      check_bit("miso masked", 1'b0, miso);
      cs2_n = 1'b1;
      tick(1);
      check_cs('1, "cs2_n high");
      check_bit("miso idle", 1'b0, miso);
    end
    periph_miso = '0;
  endtask

  task automatic test_short_frames();
    logic [15:0] rx;
    // last bit of the setup frame is 0, so a 15 bit
    // frame would land as a full led write
    spi_xfer(make_frame(LED, 8'h0a), FRAME_BITS, rx);
    m_led = sct_model(m_led, 8'h0a);
    check_led(m_led, "setup");
    spi_xfer(make_frame(LED, 8'hff), 15, rx);
    check_led(m_led, "15 bit frame");
    spi_xfer(make_frame(LED, 8'hf0), 17, rx);
    check_led(m_led, "17 bit frame");
    spi_xfer(make_frame(DAC, 8'hff), 17, rx);
    check_dac(m_dac, "17 bit frame");
  endtask

  task automatic test_clears();
    logic [15:0] rx;
    spi_xfer(make_frame(LED, 8'h0f), FRAME_BITS, rx);
    spi_xfer(make_frame(ADC, 8'h03), FRAME_BITS, rx);
    spi_xfer(make_frame(DAC, 8'h05), FRAME_BITS, rx);
    spi_xfer(make_frame(MUX, 8'd3), FRAME_BITS, rx);
    m_led = sct_model(m_led, 8'h0f);
    m_adc = sct_model(m_adc, 8'h03);
    m_dac = sct_model(m_dac, 8'h05);
    // powerup clear keeps dac and mux
    spi_xfer(make_frame(POWERUP_CLR, 8'h00), FRAME_BITS, rx);
    m_led = 4'h0;
    m_adc = 4'h0;
    check_led(m_led, "powerup clear");
    check_adc(m_adc, "powerup clear");
    check_dac(m_dac, "powerup clear");
    cs2_n = 1'b0;
    tick(1);
    check_cs(8'b1111_1011, "mux after powerup clear");
    cs2_n = 1'b1;
    // led and adc nonzero again before the soft reset
    spi_xfer(make_frame(LED, 8'h09), FRAME_BITS, rx);
    spi_xfer(make_frame(ADC, 8'h0c), FRAME_BITS, rx);
    // soft reset clears everything
    spi_xfer(make_frame(SOFT_RST, 8'h00), FRAME_BITS, rx);
    m_dac = 4'h0;
    check_led(m_led, "soft reset");
    check_adc(m_adc, "soft reset");
    check_dac(m_dac, "soft reset");
    cs2_n = 1'b0;
    tick(1);
    check_cs('1, "mux after soft reset");
    cs2_n = 1'b1;
    tick(1);
  endtask

  // sclk, mosi and data ready go straight to their pins
  task automatic test_pass_through();
    logic [2:0] pins;
    for (int i = 0; i < 8; i++)
    begin
      pins       = 3'(i);
      sclk       = pins[2];
      mosi       = pins[1];
      adc_drdy_n = pins[0];
      tick(1);
      check_bit("periph_sclk", pins[2], periph_sclk);
      check_bit("periph_mosi", pins[1], periph_mosi);
      check_bit("irq_n", pins[0], irq_n);
    end
    sclk       = 1'b0;
    mosi       = 1'b0;
    adc_drdy_n = 1'b1;
    tick(1);
  endtask

  task automatic test_heartbeat();
    logic [3:0] prev;
    int         cnt;
    prev = heartbeat;
    for (int step = 0; step < 4; step++)
    begin
      cnt = 0;
      while (heartbeat == prev && cnt < 20)
      begin
        tick(1);
        cnt++;
      end
      if (heartbeat == prev)
      begin
        $display("timeout, heartbeat did not advance");
        errors++;
        return;
      end
      if ($countones(heartbeat ^ prev) != 1)
      begin
        $display("heartbeat changed more than one bit, %h to %h", prev, heartbeat);
        errors++;
      end
      check_byte("heartbeat decoded", {4'h0, gray_to_bin(prev) + 4'd1},
                 {4'h0, gray_to_bin(heartbeat)});
      prev = heartbeat;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sequence

  initial
  begin
    int start;
    void'($urandom(32'h1b3e98a1));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    arst_n       = 1'b0;
    sclk         = 1'b0;
    cs_n         = 1'b1;
    mosi         = 1'b0;
    cs2_n        = 1'b1;
    periph_miso  = '0;
    adc_drdy_n   = 1'b1;
    m_led        = 4'h0;
    m_dac        = 4'hf;
    m_adc        = 4'h0;
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    tick(2);

    start = errors;
    test_led_sct();
    report_test("led set/clear/toggle", start);
    start = errors;
    test_dac_adc();
    report_test("dac and adc writes", start);
    start = errors;
    test_mux_route();
    report_test("mux routing", start);
    start = errors;
    test_short_frames();
    report_test("short and long frames", start);
    start = errors;
    test_clears();
    report_test("soft reset and powerup clear", start);
    start = errors;
    test_pass_through();
    report_test("pin pass-through", start);
    start = errors;
    test_heartbeat();
    report_test("heartbeat gray sequence", start);

    if (dut_i.props_i.fail_cnt != 0)
    begin
      $display("%0d bound assertion failures", dut_i.props_i.fail_cnt);
      errors += dut_i.props_i.fail_cnt;
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
common/spi_pkg.sv
common/regmap_pkg.sv
spi_slave/spi_frame_rx.sv
reg_bank/sct_reg.sv
reg_bank/reg_bank.sv
verilog/spi_route.sv
verilog/gray_blinker.sv
verilog/board_ctrl_top.sv
dv/board_ctrl_props.sv
dv/board_ctrl_tb.sv

// File: Bender.yml
package:
  name: board_ctrl

sources:
  - common/spi_pkg.sv
  - common/regmap_pkg.sv
  - spi_slave/spi_frame_rx.sv
  - reg_bank/sct_reg.sv
  - reg_bank/reg_bank.sv
  - verilog/spi_route.sv
  - verilog/gray_blinker.sv
  - verilog/board_ctrl_top.sv
  - target: test
    files:
      - dv/board_ctrl_props.sv
      - dv/board_ctrl_tb.sv
